// File: src/vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

	////////////////////////////////////////////////////////////
	// 640x480 at 60 Hz, counts are last value of each phase
	////////////////////////////////////////////////////////////

	// Screen coordinate, also used for phase counters
	typedef logic [9:0] coord_t;

	// Horizontal phases in pixel ticks
	localparam coord_t H_ACTIVE = 10'd639;
	localparam coord_t H_FRONT = 10'd15;
	localparam coord_t H_PULSE = 10'd95;
	localparam coord_t H_BACK = 10'd47;

	// Vertical phases in lines
	localparam coord_t V_ACTIVE = 10'd479;
	localparam coord_t V_FRONT = 10'd9;
	localparam coord_t V_PULSE = 10'd1;
	localparam coord_t V_BACK = 10'd32;

	// Pixel tick from the memory clock
	localparam int TICK_DIV = 4;
	localparam int TICK_W = $clog2(TICK_DIV);

	// Shared by horizontal and vertical machines
	typedef enum logic [1:0] {active, front, pulse, back} sync_phase_t;

endpackage

`default_nettype wire

// File: src/frame_pkg.sv
`default_nettype none

package frame_pkg;

	////////////////////////////////////////////////////////////
	// Frame buffer geometry
	////////////////////////////////////////////////////////////

	// Columns per row
	localparam int FRAME_W = 640;
	// Even/odd row pairs, one word per pair per bank
	localparam int PAIR_ROWS = 240;
	// Words in each bank
	localparam int BANK_DEPTH = FRAME_W * PAIR_ROWS;

	// Row pair times width plus column
	typedef logic [17:0] fb_addr_t;

	// Packed 3/3/2, red in the top bits
	typedef logic [7:0] color_t;

	////////////////////////////////////////////////////////////
	// Pixel writer sequencing
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		start_pass,
		release_solvers,
		settle,
		await_done,
		store,
		advance
	} writer_state_t;

endpackage

`default_nettype wire

// File: src/fb_write_if.sv
`default_nettype none

// One row-pair write into both banks
interface fb_write_if
	import frame_pkg::*;
();

	// Single-cycle strobe, no back-pressure
	logic we;
	fb_addr_t addr;
	// Even row colour and odd row colour at the same address
	color_t color_even;
	color_t color_odd;

	// Pixel writer side
	modport writer (output we, addr, color_even, color_odd);

	// Frame buffer side
	modport buffer (input we, addr, color_even, color_odd);

endinterface

`default_nettype wire

// File: src/pixel_writer.sv
`default_nettype none

module pixel_writer
	import vga_timing_pkg::*;
	import frame_pkg::*;
(
	input logic M10k_pll,
	input logic reset,
	// Solver results, held until solver_reset rises
	input logic done_even,
	input logic done_odd,
	input color_t color_even,
	input color_t color_odd,
	// Level release to both solvers
	output logic solver_reset,
	output coord_t pixel_x,
	output logic [7:0] pixel_row,
	fb_write_if.writer wr
);

	writer_state_t state;

	// Both solvers finished
	logic both_done;
	// Current pair is the last one of the pass
	logic last_pair;
	// End of a row pair
	logic last_col;

	assign both_done = done_even && done_odd;
	assign last_col = (pixel_x == coord_t'(FRAME_W - 1));
	assign last_pair = last_col && (pixel_row == 8'(PAIR_ROWS - 1));

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////

	// solver_reset is high in start_pass or advance, and in release
	// Coordinates only move while it is high
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			state <= start_pass;
			solver_reset <= 1'b1;
			wr.we <= 1'b0;
			pixel_x <= '0;
			pixel_row <= '0;
		end else begin
			case (state)
				// New pass from (0,0)
				start_pass: begin
					pixel_x <= '0;
					pixel_row <= '0;
					state <= release_solvers;
				end
				// Drop the level, solvers start computing
				release_solvers: begin
					solver_reset <= 1'b0;
					state <= settle;
				end
				// One spare cycle so stale done is never seen
				settle: begin
					state <= await_done;
				end
				// Strobe lands one clock after both done
				await_done: begin
					if (both_done) begin
						wr.we <= 1'b1;
						state <= store;
					end
				end
				// Write happens this cycle, park the solvers again
				store: begin
					wr.we <= 1'b0;
					solver_reset <= 1'b1;
					state <= last_pair ? start_pass : advance;
				end
				// Step to next pair, column first
				advance: begin
					if (last_col) begin
						pixel_x <= '0;
						pixel_row <= pixel_row + 8'd1;
					end else begin
						pixel_x <= pixel_x + 10'd1;
					end
					state <= release_solvers;
				end
				default: begin
					state <= start_pass;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Write payload
	////////////////////////////////////////////////////////////

	// Captured with the strobe, address from the pair position
	always_ff @(posedge M10k_pll) begin
		if ((state == await_done) && both_done) begin
			wr.addr <= fb_addr_t'(pixel_row) * fb_addr_t'(FRAME_W) + fb_addr_t'(pixel_x);
			wr.color_even <= color_even;
			wr.color_odd <= color_odd;
		end
	end

endmodule

`default_nettype wire

// File: src/frame_buffer.sv
`default_nettype none

module frame_buffer
	import vga_timing_pkg::*;
	import frame_pkg::*;
(
	input logic M10k_pll,
	// Screen position wanted by the video side
	input coord_t next_x,
	input coord_t next_y,
	fb_write_if.buffer wr,
	// Pixel at last clock's position
	output color_t color
);

	// Shared read address for both banks
	fb_addr_t rd_addr;
	// Registered bank outputs, index 0 even rows
	color_t rd_q [2];
	// Row parity aligned with rd_q
	logic odd_sel;

	// Drop the parity bit to get the row pair
	assign rd_addr = fb_addr_t'(next_y[9:1]) * fb_addr_t'(FRAME_W) + fb_addr_t'(next_x);

	////////////////////////////////////////////////////////////
	// Banks
	////////////////////////////////////////////////////////////

	for (genvar b = 0; b < 2; b++) begin : g_bank
		color_t mem [BANK_DEPTH];

		// Simple dual port, read returns old data on collision
		always_ff @(posedge M10k_pll) begin
			if (wr.we) begin
				mem[wr.addr] <= (b == 0) ? wr.color_even : wr.color_odd;
			end
			rd_q[b] <= mem[rd_addr];
		end
	end

	// Parity follows the address through the read stage
	always_ff @(posedge M10k_pll) begin
		odd_sel <= next_y[0];
	end

	// Even rows from bank 0
	assign color = odd_sel ? rd_q[1] : rd_q[0];

endmodule

`default_nettype wire

// File: src/vga_timing.sv
`default_nettype none

module vga_timing
	import vga_timing_pkg::*;
	import frame_pkg::*;
(
	input logic M10k_pll,
	input logic reset,
	// Frame buffer data for next_x/next_y
	input color_t color,
	output coord_t next_x,
	output coord_t next_y,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_blank_n,
	output logic vga_sync_n,
	output logic vga_clk
);

	// Tick divider
	logic [TICK_W-1:0] div;
	logic tick;

	// Phase machines and their counters
	sync_phase_t h_phase;
	sync_phase_t v_phase;
	coord_t h_cnt;
	coord_t v_cnt;
	// Registered end of line, one tick wide
	logic line_done;
	// Both machines showing picture
	logic in_active;

	// Last count of each phase
	function automatic coord_t h_last(input sync_phase_t ph);
		case (ph)
			active: return H_ACTIVE;
			front: return H_FRONT;
			pulse: return H_PULSE;
			default: return H_BACK;
		endcase
	endfunction

	function automatic coord_t v_last(input sync_phase_t ph);
		case (ph)
			active: return V_ACTIVE;
			front: return V_FRONT;
			pulse: return V_PULSE;
			default: return V_BACK;
		endcase
	endfunction

	// active, front, pulse, back, then around
	function automatic sync_phase_t phase_after(input sync_phase_t ph);
		case (ph)
			active: return front;
			front: return pulse;
			pulse: return back;
			default: return active;
		endcase
	endfunction

	assign tick = (div == TICK_W'(TICK_DIV - 1));
	assign in_active = (h_phase == active) && (v_phase == active);

	////////////////////////////////////////////////////////////
	// Pixel tick and clock out
	////////////////////////////////////////////////////////////

	// vga_clk rises with the outputs, falls two clocks later
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			div <= '0;
			vga_clk <= 1'b0;
		end else begin
			div <= tick ? '0 : div + 1'b1;
			if (tick) begin
				vga_clk <= 1'b1;
			end else if (div != '0) begin
				vga_clk <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Sync machines and colour
	////////////////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			h_phase <= active;
			v_phase <= active;
			h_cnt <= '0;
			v_cnt <= '0;
			line_done <= 1'b0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else if (tick) begin
			// Horizontal, counter restarts in every phase
			if (h_cnt == h_last(h_phase)) begin
				h_cnt <= '0;
				h_phase <= phase_after(h_phase);
			end else begin
				h_cnt <= h_cnt + 10'd1;
			end
			// One tick early so vertical moves with the line wrap
			line_done <= (h_phase == back) && (h_cnt == H_BACK - 10'd1);

			// Vertical steps once per line
			if (line_done) begin
				if (v_cnt == v_last(v_phase)) begin
					v_cnt <= '0;
					v_phase <= phase_after(v_phase);
				end else begin
					v_cnt <= v_cnt + 10'd1;
				end
			end

			// Syncs low in pulse, one tick behind the phase
			vga_hs <= (h_phase != pulse);
			vga_vs <= (v_phase != pulse);

			// 3/3/2 padded with zeros, black outside the picture
			vga_r <= in_active ? {color[7:5], 5'd0} : 8'd0;
			vga_g <= in_active ? {color[4:2], 5'd0} : 8'd0;
			vga_b <= in_active ? {color[1:0], 6'd0} : 8'd0;
		end
	end

	// Read position held for the whole tick
	assign next_x = (h_phase == active) ? h_cnt : 10'd0;
	assign next_y = (v_phase == active) ? v_cnt : 10'd0;

	assign vga_blank_n = vga_hs & vga_vs;
	// Composite sync not used
	assign vga_sync_n = 1'b0;

endmodule

`default_nettype wire

// File: src/mandel_display_top.sv
`default_nettype none

module mandel_display_top
	import vga_timing_pkg::*;
	import frame_pkg::*;
(
	input logic M10k_pll,
	input logic reset,
	// Solver control and coordinate
	output logic solver_reset,
	output coord_t pixel_x,
	output logic [7:0] pixel_row,
	// Solver results
	input logic done_even,
	input logic done_odd,
	input color_t color_even,
	input color_t color_odd,
	// VGA DAC
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_blank_n,
	output logic vga_sync_n,
	output logic vga_clk
);

	// Video read path
	coord_t next_x;
	coord_t next_y;
	color_t fb_color;

	// Pair writes into the buffer
	fb_write_if u_fb_wr ();

	pixel_writer u_writer (
		.M10k_pll(M10k_pll),
		.reset(reset),
		.done_even(done_even),
		.done_odd(done_odd),
		.color_even(color_even),
		.color_odd(color_odd),
		.solver_reset(solver_reset),
		.pixel_x(pixel_x),
		.pixel_row(pixel_row),
		.wr(u_fb_wr.writer)
	);

	frame_buffer u_buffer (
		.M10k_pll(M10k_pll),
		.next_x(next_x),
		.next_y(next_y),
		.wr(u_fb_wr.buffer),
		.color(fb_color)
	);

	vga_timing u_timing (
		.M10k_pll(M10k_pll),
		.reset(reset),
		.color(fb_color),
		.next_x(next_x),
		.next_y(next_y),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_blank_n(vga_blank_n),
		.vga_sync_n(vga_sync_n),
		.vga_clk(vga_clk)
	);

endmodule

`default_nettype wire

// File: test/mandel_display_assert.sv
`default_nettype none

module mandel_display_assert
	import vga_timing_pkg::*;
(
	input logic M10k_pll,
	input logic reset,
	input logic solver_reset,
	input coord_t pixel_x,
	input logic [7:0] pixel_row,
	input logic [7:0] vga_r,
	input logic [7:0] vga_g,
	input logic [7:0] vga_b,
	input logic vga_hs,
	input logic vga_vs,
	input logic vga_blank_n,
	input logic vga_sync_n,
	input logic vga_clk
);

	timeunit 1ns;
	timeprecision 1ps;

	// Line and frame lengths in clocks
	localparam int LINE_TICKS = int'(H_ACTIVE) + int'(H_FRONT) + int'(H_PULSE) + int'(H_BACK) + 4;
	localparam int FRAME_LINES = int'(V_ACTIVE) + int'(V_FRONT) + int'(V_PULSE) + int'(V_BACK) + 4;
	localparam int LINE_CLKS = LINE_TICKS * TICK_DIV;
	localparam int FRAME_CLKS = FRAME_LINES * LINE_CLKS;
	localparam int HS_LOW_CLKS = (int'(H_PULSE) + 1) * TICK_DIV;
	localparam int VS_LOW_CLKS = (int'(V_PULSE) + 1) * LINE_CLKS;

	int sync_fails = 0;
	int blank_fails = 0;
	int seq_fails = 0;

	// Clocks since the last sync fall
	logic hs_q;
	logic vs_q;
	logic hs_seen;
	logic vs_seen;
	int hs_clks;
	int vs_clks;

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			hs_q <= 1'b0;
			vs_q <= 1'b0;
			hs_seen <= 1'b0;
			vs_seen <= 1'b0;
			hs_clks <= 0;
			vs_clks <= 0;
		end else begin
			hs_q <= vga_hs;
			vs_q <= vga_vs;
			if (hs_q && !vga_hs) begin
				hs_clks <= 1;
				hs_seen <= 1'b1;
			end else begin
				hs_clks <= hs_clks + 1;
			end
			if (vs_q && !vga_vs) begin
				vs_clks <= 1;
				vs_seen <= 1'b1;
			end else begin
				vs_clks <= vs_clks + 1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Sync widths
	////////////////////////////////////////////////////////////

	assert property (@(posedge M10k_pll) disable iff (reset)
		(hs_seen && !hs_q && vga_hs) |-> hs_clks == HS_LOW_CLKS)
	else begin
		sync_fails++;
		$error("error sync widths: hsync low expected %0d clocks, actual %0d",
			HS_LOW_CLKS, $sampled(hs_clks));
	end

	assert property (@(posedge M10k_pll) disable iff (reset)
		(hs_seen && hs_q && !vga_hs) |-> hs_clks == LINE_CLKS)
	else begin
		sync_fails++;
		$error("error sync widths: hsync period expected %0d clocks, actual %0d",
			LINE_CLKS, $sampled(hs_clks));
	end

	assert property (@(posedge M10k_pll) disable iff (reset)
		(vs_seen && !vs_q && vga_vs) |-> vs_clks == VS_LOW_CLKS)
	else begin
		sync_fails++;
		$error("error sync widths: vsync low expected %0d clocks, actual %0d",
			VS_LOW_CLKS, $sampled(vs_clks));
	end

	assert property (@(posedge M10k_pll) disable iff (reset)
		(vs_seen && vs_q && !vga_vs) |-> vs_clks == FRAME_CLKS)
	else begin
		sync_fails++;
		$error("error sync widths: vsync period expected %0d clocks, actual %0d",
			FRAME_CLKS, $sampled(vs_clks));
	end

	// Pixel clock high two clocks out of every four
	assert property (@(posedge M10k_pll) disable iff (reset)
		$rose(vga_clk) |=> vga_clk ##1 !vga_clk ##1 !vga_clk ##1 vga_clk)
	else begin
		sync_fails++;
		$error("sync widths: vga_clk not high for two clocks of each four");
	end

	// Syncs only move with the pixel clock rise
	assert property (@(posedge M10k_pll) disable iff (reset)
		$changed({vga_hs, vga_vs}) |-> $rose(vga_clk))
	else begin
		sync_fails++;
		$error("sync widths: sync changed without a vga_clk rise");
	end

	////////////////////////////////////////////////////////////
	// Blanking
	////////////////////////////////////////////////////////////

	assert property (@(posedge M10k_pll) disable iff (reset)
		(!vga_hs || !vga_vs) |-> {vga_r, vga_g, vga_b} == 24'd0)
	else begin
		blank_fails++;
		$error("error blanking: expected rgb 000000 during sync, actual %h",
			$sampled({vga_r, vga_g, vga_b}));
	end

	// Blank is the AND of both syncs, composite sync tied low
	assert property (@(posedge M10k_pll) disable iff (reset)
		vga_blank_n == (vga_hs && vga_vs) && !vga_sync_n)
	else begin
		blank_fails++;
		$error("error blanking: expected blank_n=%b sync_n=0, actual blank_n=%b sync_n=%b",
			$sampled(vga_hs && vga_vs), $sampled(vga_blank_n), $sampled(vga_sync_n));
	end

	////////////////////////////////////////////////////////////
	// Solver sequencing
	////////////////////////////////////////////////////////////

	assert property (@(posedge M10k_pll) disable iff (reset)
		$rose(solver_reset) |=> solver_reset ##1 !solver_reset)
	else begin
		seq_fails++;
		$error("solver sequencing: solver reset not high for two cycles");
	end

	// Coordinate moves only under the hold level
	assert property (@(posedge M10k_pll) disable iff (reset)
		(pixel_x != $past(pixel_x) || pixel_row != $past(pixel_row))
		|-> solver_reset && $past(solver_reset))
	else begin
		seq_fails++;
		$error("solver sequencing: coordinate changed while solvers run");
	end

endmodule

bind mandel_display_top mandel_display_assert u_assert (.*);

`default_nettype wire

// File: test/tb_mandel_display.sv
`default_nettype none

module tb_mandel_display
	import vga_timing_pkg::*;
	import frame_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	// Pairs in one pass over the half frame
	localparam int PAIR_TOTAL = FRAME_W * PAIR_ROWS;
	localparam int FRAME_CYCLES = 800 * 525 * TICK_DIV;
	// Worst pass ends inside frame one, checked frame is frame two
	localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES + 640_000;
	// Ticks from hsync rise to x = 0, lines from vsync rise to y = 0
	localparam int X_START = int'(H_BACK) + 1;
	localparam int Y_START = int'(V_BACK) + 1;

	logic M10k_pll;
	logic reset;
	logic done_even;
	logic done_odd;
	color_t color_even;
	color_t color_odd;
	logic solver_reset;
	coord_t pixel_x;
	logic [7:0] pixel_row;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	logic vga_hs;
	logic vga_vs;
	logic vga_blank_n;
	logic vga_sync_n;
	logic vga_clk;

	// Run limit
	int cycles = 0;
	// Coordinate order tracking
	logic sr_q = 1'b0;
	logic cov_done = 1'b0;
	int pairs = 0;
	int exp_x = 0;
	int exp_row = 0;
	int cov_errors = 0;
	// Screen position tracking
	logic clk_q = 1'b0;
	logic hs_q = 1'b0;
	logic vs_q = 1'b0;
	int line_tick = 0;
	int line_idx = 0;
	int pix_x;
	int pix_y;
	logic frame_armed = 1'b0;
	logic frame_done = 1'b0;
	int img_errors = 0;

	mandel_display_top u_dut (.*);

	always #5 M10k_pll = ~M10k_pll;

	// Solver colour rule at screen row y
	function automatic color_t solver_color(input int x, input int y);
		return color_t'(x + 3 * y);
	endfunction

	// 3/3/2 fields into the top bits of each channel
	function automatic logic [23:0] expand_color(input color_t c);
		return {c[7:5], 5'd0, c[4:2], 5'd0, c[1:0], 6'd0};
	endfunction

	task automatic print_result(input string name, input int errors);
		if (errors == 0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: fail, %0d errors", name, errors);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Solver model
	////////////////////////////////////////////////////////////

	initial begin
		int delay;
		void'($urandom(83205));
		done_even = 1'b0;
		done_odd = 1'b0;
		color_even = '0;
		color_odd = '0;
		forever begin
			@(negedge M10k_pll);
			if (solver_reset) begin
				// Held, done cleared
				done_even = 1'b0;
				done_odd = 1'b0;
				while (solver_reset) begin
					@(negedge M10k_pll);
				end
				// 1 to 4 cycles of work after release
				delay = 1 + int'($urandom % 4);
				repeat (delay - 1) @(negedge M10k_pll);
				color_even = solver_color(pixel_x, 2 * pixel_row);
				color_odd = solver_color(pixel_x, 2 * pixel_row + 1);
				done_even = 1'b1;
				done_odd = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Pass coverage
	////////////////////////////////////////////////////////////

	// Coordinate of each pair taken at the release
	always @(negedge M10k_pll) begin
		sr_q <= solver_reset;
		if (!reset && sr_q && !solver_reset && !cov_done) begin
			if (pairs != 0 && pixel_x == 0 && pixel_row == 0) begin
				// Wrap back to the first pair
				if (pairs != PAIR_TOTAL) begin
					$display("error pass coverage: expected %0d pairs, actual %0d",
						PAIR_TOTAL, pairs);
					cov_errors = cov_errors + 1;
				end
				print_result("pass coverage", cov_errors);
				cov_done <= 1'b1;
			end else begin
				if (pixel_x != exp_x || pixel_row != exp_row) begin
					if (cov_errors == 0) begin
						$display("error pass coverage: expected x=%0d row=%0d, actual x=%0d row=%0d",
							exp_x, exp_row, pixel_x, pixel_row);
					end
					cov_errors = cov_errors + 1;
				end
				pairs = pairs + 1;
				exp_x = exp_x + 1;
				if (exp_x == FRAME_W) begin
					exp_x = 0;
					exp_row = (exp_row == PAIR_ROWS - 1) ? 0 : exp_row + 1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Display tracking
	////////////////////////////////////////////////////////////

	// Position counted in ticks from the sync edges
	always @(negedge M10k_pll) begin
		if (vga_clk && !clk_q) begin
			if (vga_hs && !hs_q) begin
				line_tick = 0;
				line_idx = line_idx + 1;
			end else begin
				line_tick = line_tick + 1;
			end
			// Vsync rises in the first back porch line
			if (vga_vs && !vs_q) begin
				line_idx = 0;
				frame_armed = frame_armed || cov_done;
			end
			pix_x = line_tick - X_START;
			pix_y = line_idx - Y_START;
			if (frame_armed && !frame_done && pix_x >= 0 && pix_x < FRAME_W &&
				pix_y >= 0 && pix_y < 2 * PAIR_ROWS) begin
				if ({vga_r, vga_g, vga_b} !== expand_color(solver_color(pix_x, pix_y))) begin
					if (img_errors == 0) begin
						$display("error displayed image at x=%0d y=%0d: expected %h, actual %h",
							pix_x, pix_y, expand_color(solver_color(pix_x, pix_y)),
							{vga_r, vga_g, vga_b});
					end
					img_errors = img_errors + 1;
				end
				if (pix_x == FRAME_W - 1 && pix_y == 2 * PAIR_ROWS - 1) begin
					print_result("displayed image", img_errors);
					frame_done <= 1'b1;
				end
			end
			hs_q = vga_hs;
			vs_q = vga_vs;
		end
		clk_q = vga_clk;
	end

	always @(posedge M10k_pll) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: checked frame not finished after %0d cycles", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Reset and report
	////////////////////////////////////////////////////////////

	initial begin
		int errs [5];
		int failed;
		M10k_pll = 1'b0;
		reset = 1'b1;
		repeat (10) @(negedge M10k_pll);
		reset = 1'b0;
		wait (frame_done);
		@(negedge M10k_pll);
		print_result("sync widths", u_dut.u_assert.sync_fails);
		print_result("blanking", u_dut.u_assert.blank_fails);
		print_result("solver sequencing", u_dut.u_assert.seq_fails);
		errs = '{u_dut.u_assert.sync_fails, u_dut.u_assert.blank_fails,
			u_dut.u_assert.seq_fails, cov_errors, img_errors};
		failed = 0;
		foreach (errs[i]) begin
			if (errs[i] != 0) begin
				failed = failed + 1;
			end
		end
		$display("%0d tests, %0d ok, %0d failed", 5, 5 - failed, failed);
		if (failed == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
src/vga_timing_pkg.sv
src/frame_pkg.sv
src/fb_write_if.sv
src/pixel_writer.sv
src/frame_buffer.sv
src/vga_timing.sv
src/mandel_display_top.sv
test/mandel_display_assert.sv
test/tb_mandel_display.sv

// File: Bender.yml
package:
  name: mandel_display

sources:
  - src/vga_timing_pkg.sv
  - src/frame_pkg.sv
  - src/fb_write_if.sv
  - src/pixel_writer.sv
  - src/frame_buffer.sv
  - src/vga_timing.sv
  - src/mandel_display_top.sv
  - target: test
    files:
      - test/mandel_display_assert.sv
      - test/tb_mandel_display.sv
